//--- verilog/fifo_consts.svh
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

// -------------------
// fifo geometry
// -------------------

// bits per stored item
`define FIFO_W 4
// storage entries
`define FIFO_DEPTH 9
// max items moved per push or pop
`define FIFO_LANES 4

// -------------------
// front panel
// -------------------

// seven-segment digits on the board
`define SEG_DIGITS 8
// 2**16 cycles of stable key level
`define DEBOUNCE_BITS_DEF 16
// digit dwell time as a power of two
`define SCAN_BITS_DEF 14

`endif

//--- verilog/fifo_pkg.sv
`default_nettype none

`include "fifo_consts.svh"

package fifo_pkg;

    // -------------------
    // plain vector types
    // -------------------

    // one stored item
    typedef logic [`FIFO_W-1:0] item_t;
    // all lanes side by side, lane 0 in the low bits
    typedef logic [`FIFO_LANES*`FIFO_W-1:0] lanes_t;
    // lane count 0..4
    typedef logic [$clog2(`FIFO_LANES+1)-1:0] lane_cnt_t;
    // fill level 0..9, also wide enough for an index
    typedef logic [$clog2(`FIFO_DEPTH+1)-1:0] occ_t;
    // one led per lane
    typedef logic [`FIFO_LANES-1:0] bar_t;
    // a is the msb, dot in bit 0
    typedef logic [7:0] seg_t;
    // one nibble per display digit
    typedef logic [`SEG_DIGITS*`FIFO_W-1:0] disp_word_t;

    // -------------------
    // bundles
    // -------------------

    // one operation request, step is a single-cycle strobe
    typedef struct packed {
        logic      step;
        lane_cnt_t n_push;
        lane_cnt_t n_pop;
    } fifo_req_t;

    // how much the fifo can take or give right now
    typedef struct packed {
        lane_cnt_t can_push;
        lane_cnt_t can_pop;
    } fifo_status_t;

    // key filter states
    typedef enum logic [1:0] {
        deb_idle,
        deb_settle,
        deb_held
    } deb_state_t;

endpackage

`default_nettype wire

//--- verilog/key_debounce.sv
`timescale 1ns/10ps
`default_nettype none

module key_debounce #(
    parameter int debounce_bits = 16
) (
    input  wire logic inc_pop,
    input  wire logic rst_n,
    input  wire logic key_in,
    output logic      press
);
    import fifo_pkg::*;

    // two-flop synchronizer, bit 1 is the safe one
    logic [1:0]               sync_q;
    logic                     key_s;
    deb_state_t               state_q;
    // counts stable-high cycles while settling
    logic [debounce_bits-1:0] cnt_q;

    assign key_s = sync_q[1];

    always_ff @(posedge inc_pop) begin
        if (!rst_n) begin
            sync_q  <= '0;
            state_q <= deb_idle;
            cnt_q   <= '0;
            press   <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], key_in};
            // pulse lasts one cycle only
            press  <= 1'b0;
            case (state_q)
                deb_idle: begin
                    // rising level starts a new stability window
                    if (key_s) begin
                        state_q <= deb_settle;
                        cnt_q   <= '0;
                    end
                end
                deb_settle: begin
                    if (!key_s) begin
                        // bounce, start over
                        state_q <= deb_idle;
                    end else if (&cnt_q) begin
                        // 2**debounce_bits high cycles seen
                        state_q <= deb_held;
                        press   <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                deb_held: begin
                    // wait for release before arming again
                    if (!key_s) begin
                        state_q <= deb_idle;
                    end
                end
                default: begin
                    state_q <= deb_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/lane_counter.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_consts.svh"

module lane_counter (
    input  wire logic           inc_pop,
    input  wire logic           rst_n,
    input  wire logic           advance,
    output fifo_pkg::lane_cnt_t count,
    output fifo_pkg::bar_t      bar
);
    import fifo_pkg::*;

    // top of the count range
    localparam lane_cnt_t max_cnt = lane_cnt_t'(`FIFO_LANES);

    logic at_max;

    assign at_max = (count == max_cnt);

    // -------------------
    // count, 0..4 then back to 0
    // -------------------

    always_ff @(posedge inc_pop) begin
        if (!rst_n) begin
            count <= '0;
        end else if (advance) begin
            if (at_max) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // -------------------
    // thermometer bar
    // -------------------

    // k set bits for a count of k
    always_ff @(posedge inc_pop) begin
        if (!rst_n) begin
            bar <= '0;
        end else if (advance) begin
            if (at_max) begin
                // wrap clears the whole bar
                bar <= '0;
            end else begin
                bar <= {bar[`FIFO_LANES-2:0], 1'b1};
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/multi_push_pop_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_consts.svh"

module multi_push_pop_fifo (
    input  wire logic                  inc_pop,
    input  wire logic                  rst_n,
    input  wire fifo_pkg::fifo_req_t   req,
    input  wire fifo_pkg::lanes_t      push_data,
    output fifo_pkg::lanes_t           pop_data,
    output fifo_pkg::fifo_status_t     status
);
    import fifo_pkg::*;

    localparam occ_t depth_occ = occ_t'(`FIFO_DEPTH);
    localparam occ_t lanes_occ = occ_t'(`FIFO_LANES);

    // -------------------
    // helpers
    // -------------------

    // index plus lane offset, modulo depth
    function automatic occ_t wrap_idx(occ_t base, lane_cnt_t offs);
        occ_t sum;
        sum = base + occ_t'(offs);
        if (sum >= depth_occ) begin
            sum = sum - depth_occ;
        end
        return sum;
    endfunction

    // limit a fill figure to the lane count
    function automatic lane_cnt_t cap_lanes(occ_t n);
        if (n >= lanes_occ) begin
            return lane_cnt_t'(`FIFO_LANES);
        end
        return lane_cnt_t'(n);
    endfunction

    function automatic lane_cnt_t min_lanes(lane_cnt_t a, lane_cnt_t b);
        return (a < b) ? a : b;
    endfunction

    // -------------------
    // state
    // -------------------

    // storage, no reset, masked by occupancy on the way out
    item_t     mem [`FIFO_DEPTH];
    // oldest item
    occ_t      head_q;
    // next free slot
    occ_t      tail_q;
    occ_t      occ_q;

    occ_t      free_cnt;
    lane_cnt_t can_push;
    lane_cnt_t can_pop;
    // accepted lanes of this step
    lane_cnt_t push_acc;
    lane_cnt_t pop_acc;

    // limits come from the state before the step
    assign free_cnt = depth_occ - occ_q;
    assign can_push = cap_lanes(free_cnt);
    assign can_pop  = cap_lanes(occ_q);

    // over-requests are clamped, nothing stalls
    assign push_acc = req.step ? min_lanes(req.n_push, can_push) : '0;
    assign pop_acc  = req.step ? min_lanes(req.n_pop, can_pop) : '0;

    always_comb begin
        status.can_push = can_push;
        status.can_pop  = can_pop;
    end

    // -------------------
    // pointers and fill level
    // -------------------

    always_ff @(posedge inc_pop) begin
        if (!rst_n) begin
            head_q <= '0;
            tail_q <= '0;
            occ_q  <= '0;
        end else if (req.step) begin
            head_q <= wrap_idx(head_q, pop_acc);
            tail_q <= wrap_idx(tail_q, push_acc);
            // never over 9, push was bounded by free space
            occ_q  <= occ_q + occ_t'(push_acc) - occ_t'(pop_acc);
        end
    end

    // write accepted lanes from lane 0 upward at the tail
    always_ff @(posedge inc_pop) begin
        for (int i = 0; i < `FIFO_LANES; i++) begin
            if (lane_cnt_t'(i) < push_acc) begin
                mem[wrap_idx(tail_q, lane_cnt_t'(i))] <= push_data[i*`FIFO_W +: `FIFO_W];
            end
        end
    end

    // -------------------
    // read window
    // -------------------

    // lane 0 oldest, empty lanes read zero
    always_comb begin
        pop_data = '0;
        for (int i = 0; i < `FIFO_LANES; i++) begin
            if (occ_t'(i) < occ_q) begin
                pop_data[i*`FIFO_W +: `FIFO_W] = mem[wrap_idx(head_q, lane_cnt_t'(i))];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/seven_seg_scan.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_consts.svh"

module seven_seg_scan #(
    parameter int scan_bits = 14
) (
    input  wire logic                 inc_pop,
    input  wire logic                 rst_n,
    input  wire fifo_pkg::disp_word_t number,
    output fifo_pkg::seg_t            abcdefgh,
    output logic [`SEG_DIGITS-1:0]    digit
);
    import fifo_pkg::*;

    // dwell divider
    logic [scan_bits-1:0] div_q;
    // nibble of the lit digit
    item_t                nibble;

    // -------------------
    // digit rotation
    // -------------------

    always_ff @(posedge inc_pop) begin
        if (!rst_n) begin
            div_q <= '0;
            // digit 0 lit first
            digit <= {{(`SEG_DIGITS-1){1'b0}}, 1'b1};
        end else begin
            div_q <= div_q + 1'b1;
            if (&div_q) begin
                digit <= {digit[`SEG_DIGITS-2:0], digit[`SEG_DIGITS-1]};
            end
        end
    end

    // one-hot enable picks nibble k for digit k
    always_comb begin
        nibble = '0;
        for (int k = 0; k < `SEG_DIGITS; k++) begin
            if (digit[k]) begin
                nibble = number[k*`FIFO_W +: `FIFO_W];
            end
        end
    end

    // -------------------
    // hex decode
    // -------------------

    // active high, dot always dark
    always_comb begin
        case (nibble)
            4'h0: abcdefgh = 8'b1111_1100;
            4'h1: abcdefgh = 8'b0110_0000;
            4'h2: abcdefgh = 8'b1101_1010;
            4'h3: abcdefgh = 8'b1111_0010;
            4'h4: abcdefgh = 8'b0110_0110;
            4'h5: abcdefgh = 8'b1011_0110;
            4'h6: abcdefgh = 8'b1011_1110;
            4'h7: abcdefgh = 8'b1110_0000;
            4'h8: abcdefgh = 8'b1111_1110;
            4'h9: abcdefgh = 8'b1111_0110;
            4'ha: abcdefgh = 8'b1110_1110;
            4'hb: abcdefgh = 8'b0011_1110;
            4'hc: abcdefgh = 8'b1001_1100;
            4'hd: abcdefgh = 8'b0111_1010;
            4'he: abcdefgh = 8'b1001_1110;
            default: abcdefgh = 8'b1000_1110;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/fifo_lab_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_lab_top #(
    parameter int debounce_bits = `DEBOUNCE_BITS_DEF,
    parameter int scan_bits     = `SCAN_BITS_DEF
) (
    input  wire logic                  inc_pop,
    input  wire logic                  rst_n,
    input  wire logic [2:0]            key,
    input  wire fifo_pkg::lanes_t      sw,
    output logic [11:0]                led,
    output fifo_pkg::seg_t             abcdefgh,
    output logic [`SEG_DIGITS-1:0]     digit,
    output fifo_pkg::lanes_t           pop_data,
    output fifo_pkg::fifo_status_t     status
);
    import fifo_pkg::*;

    // 0 pop count, 1 push count, 2 step
    logic [2:0] press;
    lane_cnt_t  pop_cnt;
    lane_cnt_t  push_cnt;
    bar_t       pop_bar;
    bar_t       push_bar;
    fifo_req_t  req;
    disp_word_t disp_word;

    // -------------------
    // keys
    // -------------------

    for (genvar k = 0; k < 3; k++) begin : gen_key
        key_debounce #(
            .debounce_bits(debounce_bits)
        ) key_i (
            .inc_pop(inc_pop),
            .rst_n  (rst_n),
            .key_in (key[k]),
            .press  (press[k])
        );
    end

    // -------------------
    // lane counters
    // -------------------

    lane_counter pop_cnt_i (
        .inc_pop(inc_pop),
        .rst_n  (rst_n),
        .advance(press[0]),
        .count  (pop_cnt),
        .bar    (pop_bar)
    );

    lane_counter push_cnt_i (
        .inc_pop(inc_pop),
        .rst_n  (rst_n),
        .advance(press[1]),
        .count  (push_cnt),
        .bar    (push_bar)
    );

    // pop bar straight, push bar mirrored so both grow toward the middle
    always_comb begin
        led      = '0;
        led[7:4] = pop_bar;
        for (int i = 0; i < `FIFO_LANES; i++) begin
            led[8+i] = push_bar[`FIFO_LANES-1-i];
        end
    end

    // -------------------
    // fifo
    // -------------------

    // step key is a plain one-cycle enable
    always_comb begin
        req.step   = press[2];
        req.n_push = push_cnt;
        req.n_pop  = pop_cnt;
    end

    multi_push_pop_fifo fifo_i (
        .inc_pop  (inc_pop),
        .rst_n    (rst_n),
        .req      (req),
        .push_data(sw),
        .pop_data (pop_data),
        .status   (status)
    );

    // -------------------
    // display
    // -------------------

    // upper four digits show switch items, lower four the fifo head
    assign disp_word = {sw, pop_data};

    seven_seg_scan #(
        .scan_bits(scan_bits)
    ) disp_i (
        .inc_pop (inc_pop),
        .rst_n   (rst_n),
        .number  (disp_word),
        .abcdefgh(abcdefgh),
        .digit   (digit)
    );

endmodule

`default_nettype wire

//--- test/fifo_lab_props.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_lab_props (
    input wire logic                   inc_pop,
    input wire logic                   rst_n,
    input wire fifo_pkg::fifo_req_t    req,
    input wire fifo_pkg::fifo_status_t status,
    input wire fifo_pkg::occ_t         occ
);
    import fifo_pkg::*;

    localparam int depth = `FIFO_DEPTH;
    localparam int lanes = `FIFO_LANES;

    // --------------------
    // fill level
    // --------------------

    occ_bound_a: assert property (@(posedge inc_pop) disable iff (!rst_n)
        int'(occ) <= depth)
        else $error("fifo occupancy above depth");

    // --------------------
    // status limits
    // --------------------

    // room offered never beyond lanes or free entries
    push_limit_a: assert property (@(posedge inc_pop) disable iff (!rst_n)
        int'(status.can_push) <= lanes && int'(status.can_push) <= depth - int'(occ))
        else $error("can_push beyond its limit");

    // items offered never beyond lanes or stored entries
    pop_limit_a: assert property (@(posedge inc_pop) disable iff (!rst_n)
        int'(status.can_pop) <= lanes && int'(status.can_pop) <= int'(occ))
        else $error("can_pop beyond its limit");

    // no step, no change
    idle_stable_a: assert property (@(posedge inc_pop) disable iff (!rst_n)
        !req.step |=> $stable(status))
        else $error("fifo status moved without a step");

endmodule

`default_nettype wire

//--- test/tb_fifo_lab.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_consts.svh"

module tb_fifo_lab;
    import fifo_pkg::*;

    // expected fifo outputs after one operation
    typedef struct packed {
        lanes_t       pop_data;
        fifo_status_t status;
    } expect_t;

    logic                   inc_pop;
    logic                   rst_n;
    logic [2:0]             key;
    lanes_t                 sw;
    logic [11:0]            led;
    seg_t                   abcdefgh;
    logic [`SEG_DIGITS-1:0] digit;
    lanes_t                 pop_data;
    fifo_status_t           status;

    integer                 seed;
    int                     errors;
    int                     checks;
    // stored items with the oldest at the front
    item_t                  model_q[$];
    int                     push_cnt_m;
    int                     pop_cnt_m;
    expect_t                exp_now;
    logic [11:0]            exp_led;
    logic                   disp_on;
    logic [`SEG_DIGITS-1:0] digit_seen;
    event                   check_ev;

    fifo_lab_top #(
        .debounce_bits(3),
        .scan_bits    (2)
    ) dut_i (
        .inc_pop (inc_pop),
        .rst_n   (rst_n),
        .key     (key),
        .sw      (sw),
        .led     (led),
        .abcdefgh(abcdefgh),
        .digit   (digit),
        .pop_data(pop_data),
        .status  (status)
    );

    bind multi_push_pop_fifo fifo_lab_props props_i (
        .inc_pop(inc_pop),
        .rst_n  (rst_n),
        .req    (req),
        .status (status),
        .occ    (occ_q)
    );

    // 4 ns period
    always #2 inc_pop = ~inc_pop;

    // --------------------
    // reference model
    // --------------------

    function automatic int min_int(input int a, input int b);
        return (a < b) ? a : b;
    endfunction

    // outputs implied by the queue as it stands
    function automatic expect_t ref_view();
        expect_t e;
        int      used;
        e    = '0;
        used = model_q.size();
        for (int i = 0; i < `FIFO_LANES; i++) begin
            if (i < used) begin
                e.pop_data[i*`FIFO_W +: `FIFO_W] = model_q[i];
            end
        end
        e.status.can_push = lane_cnt_t'(min_int(`FIFO_DEPTH - used, `FIFO_LANES));
        e.status.can_pop  = lane_cnt_t'(min_int(used, `FIFO_LANES));
        return e;
    endfunction

    // one step clamped by the contents before it
    function automatic expect_t ref_step(input int n_push, input int n_pop, input lanes_t data);
        int take;
        int give;
        take = min_int(n_pop, min_int(model_q.size(), `FIFO_LANES));
        give = min_int(n_push, min_int(`FIFO_DEPTH - model_q.size(), `FIFO_LANES));
        for (int i = 0; i < take; i++) begin
            void'(model_q.pop_front());
        end
        // lanes from 0 upward join at the back
        for (int i = 0; i < give; i++) begin
            model_q.push_back(data[i*`FIFO_W +: `FIFO_W]);
        end
        return ref_view();
    endfunction

    // pop bar in 7:4 and push bar growing down from bit 11
    function automatic logic [11:0] expected_led(input int n_push, input int n_pop);
        logic [11:0] v;
        v = '0;
        for (int j = 0; j < `FIFO_LANES; j++) begin
            if (j < n_pop) begin
                v[4+j] = 1'b1;
            end
            if (j < n_push) begin
                v[11-j] = 1'b1;
            end
        end
        return v;
    endfunction

    // active high segments with a in bit 7 and the dot dark
    function automatic seg_t seg_hex(input item_t n);
        case (n)
            4'h0: return 8'hfc;
            4'h1: return 8'h60;
            4'h2: return 8'hda;
            4'h3: return 8'hf2;
            4'h4: return 8'h66;
            4'h5: return 8'hb6;
            4'h6: return 8'hbe;
            4'h7: return 8'he0;
            4'h8: return 8'hfe;
            4'h9: return 8'hf6;
            4'ha: return 8'hee;
            4'hb: return 8'h3e;
            4'hc: return 8'h9c;
            4'hd: return 8'h7a;
            4'he: return 8'h9e;
            default: return 8'h8e;
        endcase
    endfunction

    // switch items on the upper digits and the expected fifo head on the lower
    function automatic item_t digit_nibble(input logic [`SEG_DIGITS-1:0] en);
        item_t n;
        n = '0;
        for (int k = 0; k < `SEG_DIGITS; k++) begin
            if (en[k] && k >= 4) begin
                n = sw[(k-4)*`FIFO_W +: `FIFO_W];
            end else if (en[k]) begin
                n = exp_now.pop_data[k*`FIFO_W +: `FIFO_W];
            end
        end
        return n;
    endfunction

    // --------------------
    // checkers
    // --------------------

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        errors++;
        $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, expected,
                 actual);
    endtask

    // compares after every press or step
    always begin
        @(check_ev);
        checks++;
        if (led !== exp_led) begin
            report_value("led", 32'(exp_led), 32'(led));
        end
        if (pop_data !== exp_now.pop_data) begin
            report_value("pop_data", 32'(exp_now.pop_data), 32'(pop_data));
        end
        if (status.can_push !== exp_now.status.can_push) begin
            report_value("status.can_push", 32'(exp_now.status.can_push), 32'(status.can_push));
        end
        if (status.can_pop !== exp_now.status.can_pop) begin
            report_value("status.can_pop", 32'(exp_now.status.can_pop), 32'(status.can_pop));
        end
    end

    // segments sampled mid cycle away from the edge
    always @(negedge inc_pop) begin
        if (disp_on) begin
            digit_seen = digit_seen | digit;
            if (!$onehot(digit)) begin
                errors++;
                $display("digit enable is not one-hot at %0t: %b", $time, digit);
            end else if (abcdefgh !== seg_hex(digit_nibble(digit))) begin
                report_value("abcdefgh", 32'(seg_hex(digit_nibble(digit))), 32'(abcdefgh));
            end
        end
    end

    // --------------------
    // stimulus
    // --------------------

    task automatic publish(input expect_t e);
        exp_now = e;
        exp_led = expected_led(push_cnt_m, pop_cnt_m);
        -> check_ev;
    endtask

    task automatic drive_sw(input lanes_t value);
        @(posedge inc_pop);
        #1;
        sw = value;
    endtask

    // 20 cycles high then 20 low with the pulse due in the high window
    task automatic press_key(input int k);
        logic seen;
        seen = 1'b0;
        @(posedge inc_pop);
        #1;
        key[k] = 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(negedge inc_pop);
            if (dut_i.press[k]) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            errors++;
            $display("timeout at %0t, key %0d never gave a press pulse", $time, k);
        end
        @(posedge inc_pop);
        #1;
        key[k] = 1'b0;
        for (int i = 0; i < 20; i++) begin
            @(negedge inc_pop);
        end
    endtask

    // walk both counts to their targets and check each press
    task automatic set_counts(input int n_push, input int n_pop);
        for (int i = 0; i < 5 && push_cnt_m != n_push; i++) begin
            press_key(1);
            push_cnt_m = (push_cnt_m + 1) % 5;
            publish(ref_view());
        end
        for (int i = 0; i < 5 && pop_cnt_m != n_pop; i++) begin
            press_key(0);
            pop_cnt_m = (pop_cnt_m + 1) % 5;
            publish(ref_view());
        end
    endtask

    // display model lags the fifo until the new head is published
    task automatic step_and_check();
        disp_on = 1'b0;
        press_key(2);
        publish(ref_step(push_cnt_m, pop_cnt_m, sw));
        disp_on = 1'b1;
    endtask

    initial begin
        seed       = 3;
        errors     = 0;
        checks     = 0;
        inc_pop    = 1'b0;
        rst_n      = 1'b0;
        key        = '0;
        sw         = '0;
        push_cnt_m = 0;
        pop_cnt_m  = 0;
        exp_now    = '0;
        exp_led    = '0;
        disp_on    = 1'b0;
        digit_seen = '0;

        repeat (5) @(posedge inc_pop);
        #1;
        rst_n = 1'b1;

        // reset state with the scan on digit 0
        if (digit !== `SEG_DIGITS'(1)) begin
            report_value("digit", 32'(1), 32'(digit));
        end
        publish(ref_view());
        disp_on = 1'b1;

        // six presses each so both counts wrap past 4
        repeat (6) begin
            press_key(0);
            pop_cnt_m = (pop_cnt_m + 1) % 5;
            publish(ref_view());
        end
        repeat (6) begin
            press_key(1);
            push_cnt_m = (push_cnt_m + 1) % 5;
            publish(ref_view());
        end

        // three in then back out oldest first
        drive_sw(lanes_t'($random(seed)));
        set_counts(3, 0);
        step_and_check();
        set_counts(0, 2);
        step_and_check();
        set_counts(0, 4);
        step_and_check();

        // fill past depth so the excess lanes drop
        set_counts(4, 0);
        repeat (4) begin
            drive_sw(lanes_t'($random(seed)));
            step_and_check();
        end
        set_counts(0, 4);
        repeat (2) step_and_check();
        set_counts(1, 0);
        step_and_check();
        // pop of 4 with 2 stored
        set_counts(0, 4);
        step_and_check();

        // random counts and data with mixed push and pop
        repeat (30) begin
            drive_sw(lanes_t'($random(seed)));
            set_counts($unsigned($random(seed)) % 5, $unsigned($random(seed)) % 5);
            step_and_check();
        end

        // last comparison runs before the summary
        @(posedge inc_pop);
        disp_on = 1'b0;
        if (digit_seen !== '1) begin
            errors++;
            $display("display scan never lit every digit, seen %b", digit_seen);
        end

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+verilog
verilog/fifo_pkg.sv
verilog/key_debounce.sv
verilog/lane_counter.sv
verilog/multi_push_pop_fifo.sv
verilog/seven_seg_scan.sv
verilog/fifo_lab_top.sv
test/fifo_lab_props.sv
test/tb_fifo_lab.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the fifo front panel testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_fifo_lab -f sources.f -o tb_fifo_lab
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_fifo_lab > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints its verdict into the log
if grep -q "Simulation failed" "$log"; then
    echo "failure found in $log"
    exit 1
fi

echo "no failure found in $log"
exit 0
